// File: all.f
src/cdr_pkg.sv
src/mm_pd.sv
src/mm_cdr.sv
src/cdr_snapshot.sv
src/cdr_top.sv
test/tb_cdr_top.sv

// File: run.sh
#!/bin/sh
# Build the CDR testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cdr_top \
    -f all.f

./obj_dir/Vtb_cdr_top

// File: src/cdr_pkg.sv
package cdr_pkg;

    // ADC sample width
    localparam int NADC = 8;

    // Interleaved lanes delivered per clock
    localparam int NTI = 16;

    // Interpolator code width, sized to match the integer phase
    localparam int NPI = NADC + 2;

    // Number of interpolator outputs
    localparam int NOUT = 4;

    // Fraction bits carried by the loop accumulators
    localparam int PHASE_EST_SHIFT = 16;

    // Shift-gain field width
    localparam int GAIN_W = 4;

    // Loop held at zero this many cycles after reset
    localparam int SETTLE_CYCLES = 32;

    typedef logic signed [NADC-1:0] adc_sample_t;

    typedef logic signed [NADC+1:0] phase_err_t;

    // Integer phase on top, fraction below
    typedef logic signed [NADC+1+PHASE_EST_SHIFT:0] loop_acc_t;

    typedef logic [NPI-1:0] pi_code_t;

    typedef logic [GAIN_W-1:0] gain_t;

    // Run-time loop configuration
    typedef struct packed {
        gain_t      kp;
        gain_t      ki;
        gain_t      kr;
        phase_err_t pd_offset;
        logic       en_freq_est;
        logic       en_ramp_est;
        logic       en_ext_pi_ctl;
        pi_code_t   ext_pi_ctl;
    } cdr_cfg_t;

    // Loop state, live or captured
    typedef struct packed {
        pi_code_t  phase;
        loop_acc_t freq;
        loop_acc_t ramp;
    } cdr_snap_t;

endpackage

// File: src/cdr_snapshot.sv
`timescale 1ns/1ps

module cdr_snapshot (
    input  logic               clk,
    input  logic               ext_rstb,
    input  logic               sample_req_i,
    input  cdr_pkg::cdr_snap_t state_i,
    output cdr_pkg::cdr_snap_t snap_o
);

    typedef enum logic [1:0] {
        WAIT,
        READY,
        SAMPLE
    } sampler_state_t;

    sampler_state_t state_q;

    // Request must drop before a new capture is armed
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state_q <= WAIT;
            snap_o  <= '0;
        end else begin
            case (state_q)
                WAIT: begin
                    if (!sample_req_i) begin
                        state_q <= READY;
                    end
                end
                READY: begin
                    if (sample_req_i) begin
                        state_q <= SAMPLE;
                    end
                end
                SAMPLE: begin
                    snap_o  <= state_i;
                    state_q <= WAIT;
                end
                default: begin
                    state_q <= WAIT;
                end
            endcase
        end
    end

    a_snap_only_after_sample: assert property (@(posedge clk) disable iff (!ext_rstb)
        (snap_o != $past(snap_o)) |-> $past(state_q == SAMPLE));

endmodule

// File: src/cdr_top.sv
`timescale 1ns/1ps

module cdr_top (
    input  logic                 clk,
    input  logic                 ext_rstb,
    input  logic                 ramp_clock_i,
    input  cdr_pkg::adc_sample_t din_i [cdr_pkg::NTI],
    input  cdr_pkg::cdr_cfg_t    cfg_i,
    input  logic                 sample_req_i,
    output cdr_pkg::pi_code_t    pi_ctl_o [cdr_pkg::NOUT],
    output logic                 freq_lvl_cross_o,
    output cdr_pkg::cdr_snap_t   snap_o
);

    import cdr_pkg::*;

    phase_err_t pd_err;
    cdr_snap_t  loop_state;

    mm_pd u_mm_pd (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .din_i       (din_i),
        .pd_offset_i (cfg_i.pd_offset),
        .pd_err_o    (pd_err)
    );

    mm_cdr u_mm_cdr (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .ramp_clock_i     (ramp_clock_i),
        .pd_err_i         (pd_err),
        .cfg_i            (cfg_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .state_o          (loop_state)
    );

    cdr_snapshot u_cdr_snapshot (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .sample_req_i (sample_req_i),
        .state_i      (loop_state),
        .snap_o       (snap_o)
    );

endmodule

// File: src/mm_cdr.sv
`timescale 1ns/1ps

module mm_cdr (
    input  logic                clk,
    input  logic                ext_rstb,
    input  logic                ramp_clock_i,
    input  cdr_pkg::phase_err_t pd_err_i,
    input  cdr_pkg::cdr_cfg_t   cfg_i,
    output cdr_pkg::pi_code_t   pi_ctl_o [cdr_pkg::NOUT],
    output logic                freq_lvl_cross_o,
    output cdr_pkg::cdr_snap_t  state_o
);

    import cdr_pkg::*;

    logic [$clog2(SETTLE_CYCLES)-1:0] settle_cnt;
    logic settled_q;
    logic ramp_ff;
    logic ramp_sync;

    phase_err_t phase_err_q;
    loop_acc_t  err_kp;
    loop_acc_t  err_ki;
    loop_acc_t  err_kr;

    loop_acc_t  ramp_pls_q;
    loop_acc_t  ramp_neg_q;
    loop_acc_t  ramp_pls_d;
    loop_acc_t  ramp_neg_d;

    loop_acc_t  freq_q;
    loop_acc_t  freq_d;
    loop_acc_t  freq_upd;
    loop_acc_t  prev_freq_upd_q;
    logic signed [$bits(loop_acc_t):0] freq_diff;

    loop_acc_t  phase_q;
    loop_acc_t  phase_d;
    loop_acc_t  phase_upd;
    logic signed [$bits(loop_acc_t):0] phase_sum;
    logic signed [$bits(loop_acc_t):0] up_lim;
    logic signed [$bits(loop_acc_t):0] dn_lim;
    pi_code_t   phase_int;

    // Settle counter, stops once the loop is released
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            settle_cnt <= '0;
            settled_q  <= 1'b0;
        end else if (!settled_q) begin
            settle_cnt <= settle_cnt + 1'b1;
            settled_q  <= (settle_cnt == SETTLE_CYCLES - 1);
        end
    end

    always_comb begin
        err_kp = loop_acc_t'(phase_err_q) <<< cfg_i.kp;
        err_ki = loop_acc_t'(phase_err_q) <<< cfg_i.ki;
        err_kr = loop_acc_t'(phase_err_q) <<< cfg_i.kr;

        // Separate ramp estimates for each half of the ramp clock
        ramp_pls_d = '0;
        ramp_neg_d = '0;
        if (cfg_i.en_ramp_est) begin
            ramp_pls_d = ramp_sync ? ramp_pls_q + err_kr : ramp_pls_q;
            ramp_neg_d = ramp_sync ? ramp_neg_q : ramp_neg_q + err_kr;
        end

        freq_upd  = err_ki + (ramp_sync ? ramp_pls_q : -ramp_neg_q);
        freq_d    = cfg_i.en_freq_est ? freq_q + freq_upd : freq_q;
        freq_diff = freq_upd - prev_freq_upd_q;

        phase_upd = err_kp + freq_q;
        phase_sum = phase_q + phase_upd;
        up_lim    = ((phase_q >>> PHASE_EST_SHIFT) + 1) <<< PHASE_EST_SHIFT;
        dn_lim    = ((phase_q >>> PHASE_EST_SHIFT) - 1) <<< PHASE_EST_SHIFT;

        // Integer phase moves by one code at most, fraction kept
        if (phase_sum > up_lim) begin
            phase_d = phase_q + (1 << PHASE_EST_SHIFT);
        end else if (phase_sum < dn_lim) begin
            phase_d = phase_q - (1 << PHASE_EST_SHIFT);
        end else begin
            phase_d = phase_sum[$bits(loop_acc_t)-1:0];
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_ff          <= 1'b0;
            ramp_sync        <= 1'b0;
            phase_err_q      <= '0;
            ramp_pls_q       <= '0;
            ramp_neg_q       <= '0;
            freq_q           <= '0;
            prev_freq_upd_q  <= '0;
            phase_q          <= '0;
            freq_lvl_cross_o <= 1'b0;
        end else begin
            ramp_ff          <= ramp_clock_i;
            ramp_sync        <= ramp_ff;
            phase_err_q      <= settled_q ? pd_err_i : '0;
            ramp_pls_q       <= settled_q ? ramp_pls_d : '0;
            ramp_neg_q       <= settled_q ? ramp_neg_d : '0;
            freq_q           <= settled_q ? freq_d : '0;
            prev_freq_upd_q  <= settled_q ? freq_upd : '0;
            phase_q          <= settled_q ? phase_d : '0;
            freq_lvl_cross_o <= (freq_diff > 0);
        end
    end

    assign phase_int = phase_q[PHASE_EST_SHIFT +: NPI];

    for (genvar k = 0; k < NOUT; k++) begin : g_pi_ctl
        assign pi_ctl_o[k] = cfg_i.en_ext_pi_ctl ? cfg_i.ext_pi_ctl : phase_int;
    end

    assign state_o = '{
        phase: phase_int,
        freq:  freq_q,
        ramp:  ramp_sync ? ramp_pls_q : ramp_neg_q
    };

    a_settle_zero: assert property (@(posedge clk) disable iff (!ext_rstb)
        !settled_q |=> (phase_q == '0 && freq_q == '0 &&
                        ramp_pls_q == '0 && ramp_neg_q == '0));

    // Wrap from the top code to zero counts as one step
    a_phase_step: assert property (@(posedge clk) disable iff (!ext_rstb)
        pi_code_t'(phase_int - $past(phase_int)) inside {'0, pi_code_t'(1), '1});

endmodule

// File: src/mm_pd.sv
`timescale 1ns/1ps

module mm_pd (
    input  logic                 clk,
    input  logic                 ext_rstb,
    input  cdr_pkg::adc_sample_t din_i [cdr_pkg::NTI],
    input  cdr_pkg::phase_err_t  pd_offset_i,
    output cdr_pkg::phase_err_t  pd_err_o
);

    import cdr_pkg::*;

    adc_sample_t last_q;
    logic signed [NADC+6:0] err_sum;

    // Last lane of this cycle pairs with lane 0 of the next one
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_q <= '0;
        end else begin
            last_q <= din_i[NTI-1];
        end
    end

    always_comb begin
        adc_sample_t            prev;
        logic signed [NADC+1:0] term;
        err_sum = pd_offset_i;
        prev    = last_q;
        for (int i = 0; i < NTI; i++) begin
            // cur * sgn(prev) - prev * sgn(cur), zero counted as positive
            term = (prev[NADC-1] ? -din_i[i] : din_i[i])
                 - (din_i[i][NADC-1] ? -prev : prev);
            err_sum = err_sum + term;
            prev    = din_i[i];
        end
    end

    // Clip to the detector output range
    always_comb begin
        if (err_sum > (2 ** (NADC + 1) - 1)) begin
            pd_err_o = {1'b0, {(NADC + 1){1'b1}}};
        end else if (err_sum < -(2 ** (NADC + 1))) begin
            pd_err_o = {1'b1, {(NADC + 1){1'b0}}};
        end else begin
            pd_err_o = err_sum[NADC+1:0];
        end
    end

endmodule

// File: test/tb_cdr_top.sv
`timescale 1ns/1ps

module tb_cdr_top;

    import cdr_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RST_CYCLES    = 8;
    localparam int QUIET_CYCLES  = 40;
    localparam int STEP_CYCLES   = 100;
    localparam int OVR_CYCLES    = 24;
    localparam int RESUME_CYCLES = 24;
    localparam int SNAP_CYCLES   = 32;
    localparam int FREQ_CYCLES   = 72;
    localparam int TOTAL_CYCLES  = RST_CYCLES + SETTLE_CYCLES + QUIET_CYCLES + STEP_CYCLES
                                 + OVR_CYCLES + RESUME_CYCLES + SNAP_CYCLES + FREQ_CYCLES;
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 200;

    logic        clk;
    logic        ext_rstb;
    logic        ramp_clock;
    adc_sample_t din [NTI];
    cdr_cfg_t    cfg;
    logic        sample_req;
    pi_code_t    pi_ctl [NOUT];
    logic        freq_lvl_cross;
    cdr_snap_t   snap;

    logic [NOUT*NPI-1:0] codes_flat;
    pi_code_t    code0;
    pi_code_t    code_prev;
    cdr_snap_t   snap_prev;
    int          rel_cyc;
    int          test_phase;
    logic        step_chk;
    logic        step_prev;
    logic        req_q;
    logic        req_rise;
    logic        rise_d1;
    logic        rise_d2;
    logic        cross_seen;
    adc_sample_t quiet_sample;

    cdr_top u_cdr_top (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .ramp_clock_i     (ramp_clock),
        .din_i            (din),
        .cfg_i            (cfg),
        .sample_req_i     (sample_req),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_lvl_cross),
        .snap_o           (snap)
    );

    for (genvar k = 0; k < NOUT; k++) begin : g_codes
        assign codes_flat[k*NPI +: NPI] = pi_ctl[k];
    end

    assign code0    = pi_ctl[0];
    assign step_chk = (test_phase == 3) || (test_phase == 5) || (test_phase == 6);
    assign req_rise = sample_req && !req_q;

    // History of outputs and request edges, one cycle apart
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            rel_cyc    <= 0;
            code_prev  <= '0;
            snap_prev  <= '0;
            step_prev  <= 1'b0;
            req_q      <= 1'b0;
            rise_d1    <= 1'b0;
            rise_d2    <= 1'b0;
            cross_seen <= 1'b0;
        end else begin
            if (rel_cyc < 100000) begin
                rel_cyc <= rel_cyc + 1;
            end
            code_prev <= code0;
            snap_prev <= snap;
            step_prev <= step_chk;
            req_q     <= sample_req;
            rise_d1   <= req_rise;
            rise_d2   <= rise_d1;
            if (test_phase == 6 && freq_lvl_cross) begin
                cross_seen <= 1'b1;
            end
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic drive_noise();
        @(posedge clk);
        foreach (din[i]) begin
            din[i] <= adc_sample_t'($urandom);
        end
    endtask

    // Drop is needed before the next request can arm the sampler
    task automatic request_snapshot(input int hold);
        sample_req <= 1'b1;
        wait_cycles(hold);
        sample_req <= 1'b0;
        wait_cycles(4);
    endtask

    a_settle_zero: assert property (@(posedge clk)
        (rel_cyc < SETTLE_CYCLES) |-> (codes_flat == '0 && !freq_lvl_cross && snap == '0))
        else fail_run($sformatf("[FAIL] pi_ctl_o = %h freq_lvl_cross_o = %h snap_o = %h",
            $sampled(codes_flat), $sampled(freq_lvl_cross), $sampled(snap)));

    a_quiet_zero: assert property (@(posedge clk) disable iff (!ext_rstb)
        (test_phase == 2) |-> codes_flat == '0)
        else fail_run($sformatf("[FAIL] pi_ctl_o = %h, expected 0", $sampled(codes_flat)));

    a_step_up: assert property (@(posedge clk) disable iff (!ext_rstb)
        (step_chk && step_prev) |->
            (pi_code_t'(code0 - code_prev) <= pi_code_t'(1) && codes_flat == {NOUT{code0}}))
        else fail_run($sformatf("[FAIL] pi_ctl_o = %h, previous pi_ctl_o[0] = %h",
            $sampled(codes_flat), $sampled(code_prev)));

    a_override: assert property (@(posedge clk) disable iff (!ext_rstb)
        cfg.en_ext_pi_ctl |-> codes_flat == {NOUT{cfg.ext_pi_ctl}})
        else fail_run($sformatf("[FAIL] pi_ctl_o = %h, ext_pi_ctl = %h",
            $sampled(codes_flat), $sampled(cfg.ext_pi_ctl)));

    a_snap_due: assert property (@(posedge clk) disable iff (!ext_rstb)
        rise_d2 |-> (snap != snap_prev && snap.phase == code_prev))
        else fail_run($sformatf("[FAIL] snap_o = %h, previous snap_o = %h, loop code = %h",
            $sampled(snap), $sampled(snap_prev), $sampled(code_prev)));

    a_snap_only_due: assert property (@(posedge clk) disable iff (!ext_rstb)
        (snap != snap_prev) |-> rise_d2)
        else fail_run($sformatf("[FAIL] snap_o = %h changed without a request, was %h",
            $sampled(snap), $sampled(snap_prev)));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Watchdog expired before the test sequence finished");
    end

    initial begin
        void'($urandom(32'ha288_f5aa));
        ext_rstb      <= 1'b0;
        ramp_clock    <= 1'b0;
        sample_req    <= 1'b0;
        test_phase    <= 1;
        cfg           <= '0;
        cfg.kp        <= gain_t'(10 + $urandom_range(0, 3));
        cfg.ki        <= gain_t'(2 + $urandom_range(0, 2));
        cfg.kr        <= gain_t'($urandom_range(0, 2));
        cfg.pd_offset <= phase_err_t'(1 + $urandom_range(0, 100));
        quiet_sample  <= adc_sample_t'($urandom);
        foreach (din[i]) begin
            din[i] <= adc_sample_t'($urandom);
        end

        // Noisy samples and an offset through reset and most of the settle time
        repeat (RST_CYCLES) drive_noise();
        ext_rstb <= 1'b1;
        repeat (SETTLE_CYCLES - 4) drive_noise();

        // All lanes equal, so every Mueller-Muller term cancels
        @(posedge clk);
        test_phase    <= 2;
        cfg.pd_offset <= '0;
        foreach (din[i]) begin
            din[i] <= quiet_sample;
        end
        wait_cycles(QUIET_CYCLES);

        @(posedge clk);
        test_phase    <= 3;
        cfg.pd_offset <= phase_err_t'(8 + $urandom_range(0, 23));
        wait_cycles(STEP_CYCLES);

        @(posedge clk);
        test_phase        <= 4;
        cfg.en_ext_pi_ctl <= 1'b1;
        repeat (OVR_CYCLES) begin
            cfg.ext_pi_ctl <= pi_code_t'($urandom);
            @(posedge clk);
        end
        cfg.en_ext_pi_ctl <= 1'b0;
        test_phase        <= 3;
        wait_cycles(RESUME_CYCLES);

        // Ramp clock goes high early so its synchronized copy is stable later
        @(posedge clk);
        test_phase <= 5;
        ramp_clock <= 1'b1;
        wait_cycles(4);
        request_snapshot(20);

        test_phase      <= 6;
        cfg.en_freq_est <= 1'b1;
        cfg.en_ramp_est <= 1'b1;
        wait_cycles(FREQ_CYCLES - 8);
        request_snapshot(4);

        @(posedge clk);
        if (cross_seen) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run("freq_lvl_cross_o never went high while the frequency update grew");
        end
    end

endmodule
